// ==== design/mips_settings.svh ====
// width settings shared across the miniMips design
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data and address width, one byte per bus transfer
`define mipsWidth 8

// eight registers in the register file
`define mipsRegBits 3

`define mipsInstrBytes 4   // bytes fetched per instruction word

`endif

// ==== design/isaPkg.sv ====
// instruction set types: opcode and funct enums, instruction word union
package isaPkg;

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      opRType = 6'b000000,
      opJ     = 6'b000010,
      opBeq   = 6'b000100,
      opAddi  = 6'b001000,
      opLb    = 6'b100000,
      opSb    = 6'b101000
   } opcodeT;

   typedef enum logic [5:0] {
      fnAdd = 6'b100000,
      fnSub = 6'b100010,
      fnAnd = 6'b100100,
      fnOr  = 6'b100101,
      fnSlt = 6'b101010
   } functT;

   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  shamt;
      functT       funct;
   } rTypeFieldsT;

   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;     // also the jump target, low bits only
   } iTypeFieldsT;

   // one fetched word, seen as either format
   typedef union packed {
      rTypeFieldsT rType;
      iTypeFieldsT iType;
   } instrWordT;

endpackage

// ==== design/ctrlPkg.sv ====
// control types: FSM states, ALU class and function, mux selects
package ctrlPkg;

   typedef enum logic [3:0] {
      FETCH1  = 4'b0000,
      FETCH2  = 4'b0010,
      FETCH3  = 4'b0011,
      FETCH4  = 4'b0100,
      DECODE  = 4'b0101,
      MEMADR  = 4'b0110,
      LBRD    = 4'b0111,
      LBWR    = 4'b1000,
      SBWR    = 4'b1001,
      RTYPEEX = 4'b1010,
      RTYPEWR = 4'b1011,
      BEQEX   = 4'b1100,
      JEX     = 4'b1101,
      ADDIEX  = 4'b1110,
      ADDIWR  = 4'b1111
   } ctrlStateT;

   typedef enum logic [1:0] {aluClsAdd = 2'b00, aluClsSub = 2'b01, aluClsFunct = 2'b10} aluClassT;

   // bit 2 selects the inverted operand and carry in
   typedef enum logic [2:0] {
      aluAnd = 3'b000,
      aluOr  = 3'b001,
      aluAdd = 3'b010,
      aluSub = 3'b110,
      aluSlt = 3'b111
   } aluFuncT;

   typedef enum logic [1:0] {srcBRegB, srcBOne, srcBImm, srcBImmX4} srcBSelT;
   typedef enum logic [1:0] {pcSrcAluResult, pcSrcAluOut, pcSrcJump} pcSrcSelT;

endpackage

// ==== design/ctrlIf.sv ====
// controller to datapath command and status interface
`timescale 1ns/10ps
`include "mips_settings.svh"

interface ctrlIf
   import isaPkg::*, ctrlPkg::*;
();
   logic [`mipsInstrBytes-1:0] irByteWrite;   // one byte lane per fetch state
   logic                       pcEn;
   logic                       mdrWrite;
   logic                       regWrite;
   logic                       regDst;        // rd when high, rt otherwise
   logic                       memToReg;
   logic                       iOrD;          // bus address from ALUOut when high
   logic                       srcASel;       // A register when high, PC otherwise
   srcBSelT                    srcBSel;
   pcSrcSelT                   pcSrc;
   aluClassT                   aluClass;

   // status back to the FSM
   opcodeT                     opcode;
   functT                      funct;
   logic                       zero;

   modport ctrlSide (output irByteWrite, pcEn, mdrWrite, regWrite, regDst, memToReg,
                     iOrD, srcASel, srcBSel, pcSrc, aluClass,
                     input opcode, funct, zero);
   modport dpSide   (input irByteWrite, pcEn, mdrWrite, regWrite, regDst, memToReg,
                     iOrD, srcASel, srcBSel, pcSrc, aluClass,
                     output opcode, funct, zero);
endinterface

// ==== design/regFile.sv ====
// register file with two read ports and one write port, register 0 reads zero
`timescale 1ns/10ps
`include "mips_settings.svh"

module regFile (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    regWrite,
   input  logic [`mipsRegBits-1:0] readAddrA,
   input  logic [`mipsRegBits-1:0] readAddrB,
   input  logic [`mipsRegBits-1:0] writeAddr,
   input  logic [`mipsWidth-1:0]   writeData,
   output logic [`mipsWidth-1:0]   readDataA,
   output logic [`mipsWidth-1:0]   readDataB
);
   logic [`mipsWidth-1:0] regs [2**`mipsRegBits];

   always_ff @(posedge clk)
   begin
      if (!reset)
         regs <= '{default: '0};
      else if (regWrite)
         regs[writeAddr] <= writeData;
   end

   // combinational reads
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
endmodule

// ==== design/aluUnit.sv ====
// ALU function decode and and/or/add/sub/slt datapath with zero flag
`timescale 1ns/10ps
`include "mips_settings.svh"

module aluUnit
   import isaPkg::*, ctrlPkg::*;
(
   input  logic [`mipsWidth-1:0] srcA,
   input  logic [`mipsWidth-1:0] srcB,
   input  aluClassT              aluClass,
   input  functT                 funct,
   output logic [`mipsWidth-1:0] result,
   output logic                  zero
);
   aluFuncT               aluFunc;
   logic [`mipsWidth-1:0] opB;
   logic [`mipsWidth-1:0] sum;
   logic                  overflow;
   logic                  lessThan;

   always_comb
   begin
      case (aluClass)
         aluClsAdd: aluFunc = aluAdd;   // address and pc arithmetic
         aluClsSub: aluFunc = aluSub;   // beq compare
         default:
         begin
            case (funct)
               fnSub:   aluFunc = aluSub;
               fnAnd:   aluFunc = aluAnd;
               fnOr:    aluFunc = aluOr;
               fnSlt:   aluFunc = aluSlt;
               default: aluFunc = aluAdd;
            endcase
         end
      endcase
   end

   assign opB = aluFunc[2] ? ~srcB : srcB;
   assign sum = srcA + opB + `mipsWidth'(aluFunc[2]);

   // signed less-than from the difference, corrected for overflow
   assign overflow = (srcA[`mipsWidth-1] != srcB[`mipsWidth-1]) &&
                     (sum[`mipsWidth-1] != srcA[`mipsWidth-1]);
   assign lessThan = sum[`mipsWidth-1] ^ overflow;

   always_comb
   begin
      case (aluFunc)
         aluAnd:  result = srcA & srcB;
         aluOr:   result = srcA | srcB;
         aluSlt:  result = `mipsWidth'(lessThan);
         default: result = sum;
      endcase
   end

   assign zero = (result == '0);

   // byFunct is only issued from the R-type execute state
   always_comb
   begin
      if (aluClass == aluClsFunct)
         assert final (funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt})
            else $error("R-type execute with unknown funct %b", funct);
   end
endmodule

// ==== design/controller.sv ====
// multicycle FSM, Wishbone cycle control and PC enable logic
`timescale 1ns/10ps

module controller
   import isaPkg::*, ctrlPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   ctrlIf.ctrlSide ctrl,
   input  logic    wbAck,
   output logic    wbCyc,
   output logic    wbStb,
   output logic    wbWe
);
   ctrlStateT state;
   ctrlStateT nextState;
   logic      busOn;         // low in reset and for the first cycle after it
   logic      memState;
   logic      busAck;        // ack of our own strobe
   logic      pcWrite;
   logic      pcWriteCond;

   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         state <= FETCH1;
         busOn <= 1'b0;
      end
      else
      begin
         state <= nextState;
         busOn <= 1'b1;
      end
   end

   // --------------------------------------------------------------------------
   // bus cycle control
   // --------------------------------------------------------------------------
   assign memState = state inside {FETCH1, FETCH2, FETCH3, FETCH4, LBRD, SBWR};
   assign wbCyc    = busOn & memState;
   assign wbStb    = wbCyc;
   assign wbWe     = wbCyc & (state == SBWR);
   assign busAck   = wbStb & wbAck;

   // memory states wait here for ack
   always_comb
   begin
      nextState = state;
      case (state)
         FETCH1:  if (busAck) nextState = FETCH2;
         FETCH2:  if (busAck) nextState = FETCH3;
         FETCH3:  if (busAck) nextState = FETCH4;
         FETCH4:  if (busAck) nextState = DECODE;
         DECODE:
         begin
            case (ctrl.opcode)
               opAddi:       nextState = ADDIEX;
               opLb, opSb:   nextState = MEMADR;
               opRType:      nextState = RTYPEEX;
               opBeq:        nextState = BEQEX;
               opJ:          nextState = JEX;
               default:      nextState = FETCH1;   // unsupported opcode
            endcase
         end
         MEMADR:  nextState = (ctrl.opcode == opLb) ? LBRD : SBWR;
         LBRD:    if (busAck) nextState = LBWR;
         SBWR:    if (busAck) nextState = FETCH1;
         ADDIEX:  nextState = ADDIWR;
         RTYPEEX: nextState = RTYPEWR;
         default: nextState = FETCH1;   // all writeback and branch states
      endcase
   end

   // --------------------------------------------------------------------------
   // datapath commands
   // --------------------------------------------------------------------------
   always_comb
   begin
      ctrl.irByteWrite = '0;
      ctrl.mdrWrite    = 1'b0;
      ctrl.regWrite    = 1'b0;
      ctrl.regDst      = 1'b0;
      ctrl.memToReg    = 1'b0;
      ctrl.iOrD        = 1'b0;
      ctrl.srcASel     = 1'b0;
      ctrl.srcBSel     = srcBRegB;
      ctrl.pcSrc       = pcSrcAluResult;
      ctrl.aluClass    = aluClsAdd;
      pcWrite          = 1'b0;
      pcWriteCond      = 1'b0;
      case (state)
         FETCH1, FETCH2, FETCH3, FETCH4:
         begin
            ctrl.irByteWrite = {state == FETCH4, state == FETCH3,
                                state == FETCH2, state == FETCH1} & {4{busAck}};
            ctrl.srcBSel     = srcBOne;   // pc + 1 per byte
            pcWrite          = busAck;
         end
         DECODE:  ctrl.srcBSel = srcBImmX4;   // branch target into ALUOut
         // the load/store address is recomputed while the bus waits
         MEMADR, LBRD, SBWR:
         begin
            ctrl.srcASel  = 1'b1;
            ctrl.srcBSel  = srcBImm;
            ctrl.iOrD     = (state != MEMADR);
            ctrl.mdrWrite = (state == LBRD) & busAck;
         end
         LBWR:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
         end
         ADDIEX:
         begin
            ctrl.srcASel = 1'b1;
            ctrl.srcBSel = srcBImm;
         end
         ADDIWR:  ctrl.regWrite = 1'b1;
         RTYPEEX:
         begin
            ctrl.srcASel  = 1'b1;
            ctrl.aluClass = aluClsFunct;
         end
         RTYPEWR:
         begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         BEQEX:
         begin
            ctrl.srcASel  = 1'b1;
            ctrl.aluClass = aluClsSub;
            ctrl.pcSrc    = pcSrcAluOut;
            pcWriteCond   = 1'b1;
         end
         JEX:
         begin
            ctrl.pcSrc = pcSrcJump;
            pcWrite    = 1'b1;
         end
         default: ;
      endcase
   end

   assign ctrl.pcEn = pcWrite | (pcWriteCond & ctrl.zero);

   // a store strobe stays put until its ack
   assert property (@(posedge clk) disable iff (!reset)
                    wbWe && !wbAck |=> wbWe && state == SBWR);
endmodule

// ==== design/datapath.sv ====
// datapath with instruction register, PC, MDR, A/B/ALUOut and the operand muxes
`timescale 1ns/10ps
`include "mips_settings.svh"

module datapath
   import isaPkg::*, ctrlPkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   ctrlIf.dpSide                 ctrl,
   input  logic [`mipsWidth-1:0] wbDatIn,
   output logic [`mipsWidth-1:0] wbAdr,
   output logic [`mipsWidth-1:0] wbDatOut
);
   instrWordT               instr;
   logic [`mipsWidth-1:0]   pc;
   logic [`mipsWidth-1:0]   nextPc;
   logic [`mipsWidth-1:0]   mdr;
   logic [`mipsWidth-1:0]   regA;
   logic [`mipsWidth-1:0]   regB;
   logic [`mipsWidth-1:0]   aluOut;
   logic [`mipsWidth-1:0]   readDataA;
   logic [`mipsWidth-1:0]   readDataB;
   logic [`mipsWidth-1:0]   srcA;
   logic [`mipsWidth-1:0]   srcB;
   logic [`mipsWidth-1:0]   aluResult;
   logic [`mipsWidth-1:0]   writeData;
   logic [`mipsWidth-1:0]   immX4;      // word offset and jump target
   logic [`mipsRegBits-1:0] writeReg;

   // --------------------------------------------------------------------------
   // state registers
   // --------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         instr  <= '0;
         pc     <= '0;
         mdr    <= '0;
         regA   <= '0;
         regB   <= '0;
         aluOut <= '0;
      end
      else
      begin
         for (int i = 0; i < `mipsInstrBytes; i++)
         begin
            if (ctrl.irByteWrite[i])
               instr[i*`mipsWidth +: `mipsWidth] <= wbDatIn;   // little-endian lanes
         end
         if (ctrl.pcEn)
            pc <= nextPc;
         if (ctrl.mdrWrite)
            mdr <= wbDatIn;
         regA   <= readDataA;
         regB   <= readDataB;
         aluOut <= aluResult;
      end
   end

   assign immX4 = {instr.iType.imm[`mipsWidth-3:0], 2'b00};

   assign writeReg  = ctrl.regDst ? instr.rType.rd[`mipsRegBits-1:0]
                                  : instr.iType.rt[`mipsRegBits-1:0];
   assign writeData = ctrl.memToReg ? mdr : aluOut;
   assign srcA      = ctrl.srcASel ? regA : pc;

   always_comb
   begin
      case (ctrl.srcBSel)
         srcBOne:   srcB = `mipsWidth'(1);
         srcBImm:   srcB = instr.iType.imm[`mipsWidth-1:0];
         srcBImmX4: srcB = immX4;
         default:   srcB = regB;
      endcase
      case (ctrl.pcSrc)
         pcSrcAluOut: nextPc = aluOut;
         pcSrcJump:   nextPc = immX4;
         default:     nextPc = aluResult;
      endcase
   end

   assign wbAdr    = ctrl.iOrD ? aluOut : pc;
   assign wbDatOut = regB;   // store data is rt

   assign ctrl.opcode = instr.iType.opcode;
   assign ctrl.funct  = instr.rType.funct;

   regFile u_regFile (
      .clk       (clk),
      .reset     (reset),
      .regWrite  (ctrl.regWrite),
      .readAddrA (instr.iType.rs[`mipsRegBits-1:0]),
      .readAddrB (instr.iType.rt[`mipsRegBits-1:0]),
      .writeAddr (writeReg),
      .writeData (writeData),
      .readDataA (readDataA),
      .readDataB (readDataB)
   );

   aluUnit u_aluUnit (
      .srcA     (srcA),
      .srcB     (srcB),
      .aluClass (ctrl.aluClass),
      .funct    (ctrl.funct),
      .result   (aluResult),
      .zero     (ctrl.zero)
   );

   assert property (@(posedge clk) disable iff (!reset)
                    (ctrl.pcEn || ctrl.mdrWrite) |-> !$isunknown(wbAdr));
endmodule

// ==== design/miniMips.sv ====
// miniMips top level: controller and datapath on a Wishbone classic master port
`timescale 1ns/10ps
`include "mips_settings.svh"

module miniMips (
   input  logic                  clk,
   input  logic                  reset,
   output logic                  wbCyc,
   output logic                  wbStb,
   output logic                  wbWe,
   output logic [`mipsWidth-1:0] wbAdr,
   output logic [`mipsWidth-1:0] wbDatOut,
   input  logic [`mipsWidth-1:0] wbDatIn,
   input  logic                  wbAck
);
   ctrlIf u_ctrlIf ();

   // fsm owns the handshake
   controller u_controller (
      .clk   (clk),
      .reset (reset),
      .ctrl  (u_ctrlIf.ctrlSide),
      .wbAck (wbAck),
      .wbCyc (wbCyc),
      .wbStb (wbStb),
      .wbWe  (wbWe)
   );

   datapath u_datapath (
      .clk      (clk),
      .reset    (reset),
      .ctrl     (u_ctrlIf.dpSide),
      .wbDatIn  (wbDatIn),
      .wbAdr    (wbAdr),      // pc or ALUOut
      .wbDatOut (wbDatOut)
   );
endmodule

// ==== dv/tbMemory.sv ====
// Wishbone classic slave memory with random ack wait states and the test program image
`timescale 1ns/10ps
`include "mips_settings.svh"

module tbMemory #(
   parameter int unsigned seed = 1
) (
   input  logic                  clk,
   input  logic                  wbCyc,
   input  logic                  wbStb,
   input  logic                  wbWe,
   input  logic [`mipsWidth-1:0] wbAdr,
   input  logic [`mipsWidth-1:0] wbDatOut,
   output logic [`mipsWidth-1:0] wbDatIn,
   output logic                  wbAck
);
   localparam logic [5:0] rTypeOp = 6'b000000;
   localparam logic [5:0] jOp     = 6'b000010;
   localparam logic [5:0] beqOp   = 6'b000100;
   localparam logic [5:0] addiOp  = 6'b001000;
   localparam logic [5:0] lbOp    = 6'b100000;
   localparam logic [5:0] sbOp    = 6'b101000;

   logic [`mipsWidth-1:0] mem [2**`mipsWidth];
   logic [31:0]           image [$];

   function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
                                           input logic [5:0] funct);
      return {rTypeOp, 5'(rs), 5'(rt), 5'(rd), 5'b00000, funct};
   endfunction

   function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
                                           input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic logic [31:0] encodeJ(input int target);
      return {jOp, 26'(target)};   // word index of the target
   endfunction

   // -------------------------------------------------------------------------
   // program image, one word per line, byte address is four times the index
   // -------------------------------------------------------------------------
   initial
   begin
      for (int a = 0; a < 2**`mipsWidth; a++)
         mem[a] = 8'(a) ^ 8'h5A;                        // fill follows the address
      image.push_back(encodeI(addiOp, 0, 1, 16'd23));   // 0  addi r1, r0, 23
      image.push_back(encodeI(addiOp, 0, 2, 16'd45));   // 1  addi r2, r0, 45
      image.push_back(encodeI(addiOp, 1, 3, 16'd10));   // 2  addi r3, r1, 10
      image.push_back(encodeI(sbOp, 0, 3, 16'h00C0));   // 3  sb r3, 0xc0(r0)
      image.push_back(encodeR(1, 2, 4, 6'b100000));     // 4  add r4, r1, r2
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C1));   // 5
      image.push_back(encodeR(1, 2, 4, 6'b100010));     // 6  sub
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C2));   // 7
      image.push_back(encodeR(1, 2, 4, 6'b100100));     // 8  and
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C3));   // 9
      image.push_back(encodeR(1, 2, 4, 6'b100101));     // 10 or
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C4));   // 11
      image.push_back(encodeR(1, 2, 4, 6'b101010));     // 12 slt r4, r1, r2
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C5));   // 13
      image.push_back(encodeR(2, 1, 4, 6'b101010));     // 14 slt r4, r2, r1
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C6));   // 15
      image.push_back(encodeI(addiOp, 0, 5, 16'h00F0)); // 16 addi r5, r0, -16
      image.push_back(encodeR(5, 1, 4, 6'b101010));     // 17 slt r4, r5, r1
      image.push_back(encodeI(sbOp, 0, 4, 16'h00C7));   // 18
      image.push_back(encodeI(lbOp, 0, 6, 16'h00E0));   // 19 lb r6, 0xe0(r0)
      image.push_back(encodeI(sbOp, 0, 6, 16'h00C8));   // 20
      image.push_back(encodeI(addiOp, 0, 0, 16'd77));   // 21 addi r0, r0, 77
      image.push_back(encodeI(sbOp, 0, 0, 16'h00C9));   // 22 sb r0, 0xc9(r0)
      image.push_back(encodeI(beqOp, 1, 1, 16'd1));     // 23 beq r1, r1, taken
      image.push_back(encodeI(sbOp, 0, 1, 16'h00CA));   // 24 skipped
      image.push_back(encodeI(sbOp, 0, 2, 16'h00CB));   // 25
      image.push_back(encodeI(beqOp, 1, 2, 16'd1));     // 26 beq r1, r2, not taken
      image.push_back(encodeI(sbOp, 0, 1, 16'h00CC));   // 27
      image.push_back(encodeJ(30));                     // 28 j 30
      image.push_back(encodeI(sbOp, 0, 1, 16'h00CD));   // 29 skipped
      image.push_back(encodeI(addiOp, 0, 7, 16'h005A)); // 30 marker value
      image.push_back(encodeI(sbOp, 0, 7, 16'h00CE));   // 31
      image.push_back(encodeJ(32));                     // 32 spin here
      for (int i = 0; i < image.size(); i++)
      begin
         for (int b = 0; b < `mipsInstrBytes; b++)
            mem[`mipsInstrBytes*i + b] = image[i][b*`mipsWidth +: `mipsWidth];
      end
      mem[8'hE0] = 8'h9C;   // load source byte
   end

   // one transfer at a time, ack after 0 to 3 wait cycles
   initial
   begin
      int   waitCnt;
      logic pending;
      void'($urandom(seed));
      wbAck   = 1'b0;
      wbDatIn = '0;
      pending = 1'b0;
      waitCnt = 0;
      forever
      begin
         @(posedge clk);
         #1;
         if (wbAck)
         begin
            wbAck   = 1'b0;   // transfer ended on this edge
            pending = 1'b0;
         end
         if (wbCyc && wbStb && !pending)
         begin
            pending = 1'b1;
            waitCnt = $urandom % 4;
         end
         if (pending)
         begin
            if (waitCnt == 0)
            begin
               wbAck = 1'b1;
               if (wbWe)
                  mem[wbAdr] = wbDatOut;
               else
                  wbDatIn = mem[wbAdr];
            end
            else
               waitCnt--;
         end
      end
   end
endmodule

// ==== dv/tbMiniMips.sv ====
// testbench top: clock, reset, expected store table, bus checks, watchdog and summary
`timescale 1ns/10ps
`include "mips_settings.svh"

module tbMiniMips;
   localparam int clkPeriod   = 20;
   localparam int resetCycles = 16;

   logic                  clk;
   logic                  reset;
   logic                  wbCyc;
   logic                  wbStb;
   logic                  wbWe;
   logic [`mipsWidth-1:0] wbAdr;
   logic [`mipsWidth-1:0] wbDatOut;
   logic [`mipsWidth-1:0] wbDatIn;
   logic                  wbAck;

   int                    errorCount;
   int                    checkCount;
   int                    readCount;    // fetch reads seen since reset
   int                    storeCount;
   string                 expName [$];
   logic [`mipsWidth-1:0] expAdr [$];
   logic [`mipsWidth-1:0] expDat [$];

   miniMips u_miniMips (
      .clk      (clk),
      .reset    (reset),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbWe     (wbWe),
      .wbAdr    (wbAdr),
      .wbDatOut (wbDatOut),
      .wbDatIn  (wbDatIn),
      .wbAck    (wbAck)
   );

   tbMemory #(.seed(61064)) u_tbMemory (
      .clk      (clk),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbWe     (wbWe),
      .wbAdr    (wbAdr),
      .wbDatOut (wbDatOut),
      .wbDatIn  (wbDatIn),
      .wbAck    (wbAck)
   );

   initial
      clk = 1'b0;
   always #(clkPeriod/2) clk = ~clk;

   // signed 8-bit set-less-than
   function automatic logic [`mipsWidth-1:0] sltRef(input logic [`mipsWidth-1:0] a,
                                                    input logic [`mipsWidth-1:0] b);
      return ($signed(a) < $signed(b)) ? `mipsWidth'(1) : `mipsWidth'(0);
   endfunction

   task automatic expectStore(input string name, input logic [`mipsWidth-1:0] adr,
                              input logic [`mipsWidth-1:0] dat);
      expName.push_back(name);
      expAdr.push_back(adr);
      expDat.push_back(dat);
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   // next completed write transfer, seen at the falling edge
   task automatic waitStore();
      @(negedge clk);
      while (!(wbCyc && wbStb && wbWe && wbAck))
         @(negedge clk);
   endtask

   // ------------------------------------------------------------------------
   // bus protocol monitor
   // ------------------------------------------------------------------------
   always @(negedge clk)
   begin
      if (reset)
      begin
         if (wbStb)
            checkValue("wbCyc while wbStb", wbCyc, 1'b1);
         if (wbCyc && wbStb && wbAck && readCount < `mipsInstrBytes)
         begin
            checkValue("wbWe of first fetch", wbWe, 1'b0);
            checkValue("wbAdr of first fetch", wbAdr, readCount);
            readCount++;
         end
      end
   end

   initial
   begin
      errorCount = 0;
      checkCount = 0;
      readCount  = 0;
      storeCount = 0;
      reset      = 1'b0;
      expectStore("addi", 8'hC0, 8'(23 + 10));
      expectStore("add", 8'hC1, 8'(23 + 45));
      expectStore("sub", 8'hC2, 8'(23 - 45));
      expectStore("and", 8'hC3, 8'(23 & 45));
      expectStore("or", 8'hC4, 8'(23 | 45));
      expectStore("slt less", 8'hC5, sltRef(8'd23, 8'd45));
      expectStore("slt greater", 8'hC6, sltRef(8'd45, 8'd23));
      expectStore("slt signed", 8'hC7, sltRef(8'hF0, 8'd23));
      expectStore("lb", 8'hC8, 8'h9C);
      expectStore("register 0", 8'hC9, 8'h00);
      expectStore("beq taken", 8'hCB, 8'd45);
      expectStore("beq not taken", 8'hCC, 8'd23);
      expectStore("j", 8'hCE, 8'h5A);
      repeat (resetCycles) @(posedge clk);
      #1 reset = 1'b1;
      for (int i = 0; i < expAdr.size(); i++)
      begin
         waitStore();
         checkValue({"wbAdr for ", expName[i]}, wbAdr, expAdr[i]);
         checkValue({"wbDatOut for ", expName[i]}, wbDatOut, expDat[i]);
         storeCount++;
      end
      $display("%0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // generous bound per table entry
   initial
   begin
      @(posedge reset);
      #(expAdr.size() * 40 * 8 * clkPeriod);
      $display("Timeout: the expected stores never arrived, %0d of %0d seen, %0d errors",
               storeCount, expAdr.size(), errorCount);
      $display("SIMULATION FAILED");
      $finish;
   end
endmodule

// ==== all.f ====
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/ctrlIf.sv
design/regFile.sv
design/aluUnit.sv
design/controller.sv
design/datapath.sv
design/miniMips.sv
dv/tbMemory.sv
dv/tbMiniMips.sv
